// ==== vlog.f ====
+incdir+hdl
hdl/axi_pkg.sv
hdl/vadd_pkg.sv
hdl/axi_word_mem.sv
hdl/burst_reader.sv
hdl/lane_adder.sv
hdl/burst_writer.sv
hdl/vadd_top.sv
tb/vadd_props.sv
tb/vadd_tb.sv

// ==== tb/vadd_tb.sv ====
// Directed testbench for the vector-add engine, compares done, resp and checksum with a model
`timescale 1ns/1ps
`include "vadd_settings.svh"

module vadd_tb;

	localparam int CLK_PERIOD = 20;
	localparam int MAX_LEN    = 256;          // Longest burst in beats
	localparam int N_TESTS    = 6;
	localparam int DONE_LIMIT = MAX_LEN + 20; // Cycles allowed per command

	logic                        clk;
	logic                        rst_n;
	logic                        start;
	vadd_pkg::mode_t             mode;
	logic [`VADD_ADDR_WIDTH-1:0] src_a;
	logic [`VADD_ADDR_WIDTH-1:0] src_b;
	logic [`VADD_ADDR_WIDTH-1:0] dst;
	axi_pkg::len_t               len;
	logic                        busy;
	logic                        done;
	axi_pkg::resp_t              resp;
	logic [`VADD_DATA_WIDTH-1:0] checksum;

	logic [`VADD_DATA_WIDTH-1:0] model_mem [`VADD_MEM_WORDS]; // Shadow of the DUT memory
	logic [`VADD_DATA_WIDTH-1:0] exp_sum;                      // Checksum of the last command
	int                          errors;
	int                          checks;
	int                          seed;

	vadd_top dut_i (
		.clk(clk), .rst_n(rst_n), .start(start), .mode(mode),
		.src_a(src_a), .src_b(src_b), .dst(dst), .len(len),
		.busy(busy), .done(done), .resp(resp), .checksum(checksum)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(logic cond, string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check error: %s", what);
		end
	endtask

	// Reset content rule, i times 0x00010003
	function automatic logic [31:0] pattern_word(int i);
		return 32'(i) * 32'h0001_0003;
	endfunction

	// Lane mode adds low 7 bits, then fixes each lane's top bit without carry out
	function automatic logic [31:0] add_rule(logic [31:0] a, logic [31:0] b, vadd_pkg::mode_t m);
		if (m == vadd_pkg::MODE_LANE)
			return ((a & 32'h7f7f_7f7f) + (b & 32'h7f7f_7f7f)) ^ ((a ^ b) & 32'h8080_8080);
		return a + b;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < `VADD_MEM_WORDS; i++)
			model_mem[i] = pattern_word(i);
	endtask

	// Reads all sources before storing, regions never overlap here
	task automatic model_cmd(vadd_pkg::mode_t m, logic [9:0] a, logic [9:0] b, logic [9:0] d,
			axi_pkg::len_t l, output logic [31:0] csum);
		logic [31:0] res [MAX_LEN];
		logic [9:0]  k;
		csum = '0;
		for (int i = 0; i <= l; i++) begin
			k = 10'(i);
			res[i] = add_rule(model_mem[a + k], model_mem[b + k], m);
			csum += res[i]; // Wraps at 32 bits
		end
		for (int i = 0; i <= l; i++)
			model_mem[d + 10'(i)] = res[i];
	endtask

	// One start pulse, fields held with it
	task automatic issue(vadd_pkg::mode_t m, logic [9:0] a, logic [9:0] b, logic [9:0] d,
			axi_pkg::len_t l);
		model_cmd(m, a, b, d, l, exp_sum);
		@(posedge clk);
		start <= 1'b1;
		mode  <= m;
		src_a <= a;
		src_b <= b;
		dst   <= d;
		len   <= l;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_value("busy", busy, 1'b1); // Cycle after start
		check_value("done", done, 1'b0);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk);
		while (!done && n < DONE_LIMIT) begin
			check_value("busy", busy, 1'b1);
			@(negedge clk);
			n++;
		end
		check_flag(done === 1'b1, "done did not arrive within the allowed cycles");
		if (done) begin
			check_value("busy", busy, 1'b0);
			check_value("resp", resp, axi_pkg::RESP_OKAY);
			check_value("checksum", checksum, exp_sum);
			@(negedge clk);
			check_value("done", done, 1'b0); // One-cycle pulse
		end
	endtask

	task automatic test_single_word();
		issue(vadd_pkg::MODE_WORD, 10'h010, 10'h020, 10'h300, 8'd0);
		wait_done();
		check_value("checksum", checksum, pattern_word(16) + pattern_word(32));
	endtask

	task automatic test_random_burst();
		logic [9:0] a;
		logic [9:0] b;
		logic [9:0] d;
		a = 10'h000 + 10'($random(seed) & 32'h7f); // Separate 256-word windows
		b = 10'h100 + 10'($random(seed) & 32'h7f);
		d = 10'h200 + 10'($random(seed) & 32'h7f);
		issue(vadd_pkg::MODE_WORD, a, b, d, 8'd15);
		wait_done();
	endtask

	task automatic test_lane_carry();
		logic [31:0] word_csum;
		word_csum = '0;
		for (int i = 0; i < 16; i++)
			word_csum += model_mem[10'h050 + i] + model_mem[10'h060 + i];
		// Low bytes near 0xf0 and 0x20 carry out of lane 0
		issue(vadd_pkg::MODE_LANE, 10'h050, 10'h060, 10'h340, 8'd15);
		wait_done();
		check_flag(checksum != word_csum, "lane-mode checksum equals the word-mode value");
	endtask

	task automatic test_chained();
		issue(vadd_pkg::MODE_WORD, 10'h010, 10'h030, 10'h380, 8'd7);
		wait_done();
		issue(vadd_pkg::MODE_WORD, 10'h380, 10'h040, 10'h3c0, 8'd7); // Reads back the first result
		wait_done();
	endtask

	task automatic test_host_protocol();
		issue(vadd_pkg::MODE_WORD, 10'h0c0, 10'h0e0, 10'h3e0, 8'd5);
		@(posedge clk);
		start <= 1'b1; // Must be dropped while busy
		mode  <= vadd_pkg::MODE_LANE;
		src_a <= 10'h3f0;
		dst   <= 10'h000;
		@(posedge clk);
		start <= 1'b0;
		wait_done();
		repeat (4) begin
			@(negedge clk);
			check_value("busy", busy, 1'b0);
			check_value("done", done, 1'b0);
		end
	endtask

	task automatic test_reset_mid();
		issue(vadd_pkg::MODE_WORD, 10'h080, 10'h180, 10'h280, 8'd15);
		repeat (6) @(negedge clk); // Inside the burst
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		check_value("busy", busy, 1'b0);
		check_value("checksum", checksum, 32'h0);
		check_value("done", done, 1'b0);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		reset_model(); // Memory reloads its pattern
		// Operand A sits where an earlier command wrote its results
		issue(vadd_pkg::MODE_WORD, 10'h380, 10'h105, 10'h205, 8'd3);
		wait_done();
	endtask

	initial begin
		#(N_TESTS * (MAX_LEN + 20) * CLK_PERIOD);
		$display("Watchdog expired at %0t, the run hung waiting on the DUT", $time);
		$display("Regression failed");
		$finish;
	end

	initial begin
		clk    = 1'b0;
		rst_n  = 1'b0;
		start  = 1'b0;
		mode   = vadd_pkg::MODE_WORD;
		src_a  = '0;
		src_b  = '0;
		dst    = '0;
		len    = '0;
		errors = 0;
		checks = 0;
		seed   = 32'hc59a_15e8;
		reset_model();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_single_word();
		test_random_burst();
		test_lane_carry();
		test_chained();
		test_host_protocol();
		test_reset_mid();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tb/vadd_props.sv ====
// Protocol checks on the burst memory channels, bound into the memory inside the engine
`timescale 1ns/1ps

module vadd_props (
	input logic clk,
	input logic rst_n,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic wlast,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic rlast,
	input logic rvalid_2,
	input logic rready_2,
	input logic rlast_2
);

	logic in_burst; // aw taken, wlast beat not yet

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			in_burst <= 1'b0;
		else if (wvalid && wready && wlast)
			in_burst <= 1'b0; // Burst closed
		else if (awvalid && awready)
			in_burst <= 1'b1;
	end

	// wready opens together with awready
	wready_pending: assert property (@(posedge clk) disable iff (!rst_n)
		wready |-> (awready || in_burst)) else $error("wready high with no write burst");

	rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !(rready && rlast) |=> rvalid) else $error("rvalid dropped before rlast");

	rvalid_2_held: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid_2 && !(rready_2 && rlast_2) |=> rvalid_2) else $error("rvalid_2 dropped early");

	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

endmodule

bind axi_word_mem vadd_props props_i (.*);

// ==== hdl/vadd_top.sv ====
// Top level of the vector-add engine, takes host commands and links the pipeline to memory
`timescale 1ns/1ps
`include "vadd_settings.svh"

module vadd_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  vadd_pkg::mode_t             mode,
	input  logic [`VADD_ADDR_WIDTH-1:0] src_a,
	input  logic [`VADD_ADDR_WIDTH-1:0] src_b,
	input  logic [`VADD_ADDR_WIDTH-1:0] dst,
	input  axi_pkg::len_t               len,
	output logic                        busy,
	output logic                        done,
	output axi_pkg::resp_t              resp,
	output logic [`VADD_DATA_WIDTH-1:0] checksum
);

	logic                        start_ok; // Start outside a command
	vadd_pkg::mode_t             mode_q;

	logic [`VADD_ADDR_WIDTH-1:0] awaddr;
	axi_pkg::len_t               awlen;
	logic                        awvalid, awready;
	logic [`VADD_DATA_WIDTH-1:0] wdata;
	logic                        wvalid, wlast, wready;
	axi_pkg::resp_t              bresp;
	logic                        bvalid, bready;

	logic [`VADD_ADDR_WIDTH-1:0] araddr_a, araddr_b;
	axi_pkg::len_t               arlen_a, arlen_b;
	logic                        arvalid_a, arvalid_b, arready_a, arready_b;
	logic [`VADD_DATA_WIDTH-1:0] rdata_a, rdata_b;
	logic                        rvalid_a, rvalid_b, rlast_a, rready_a, rready_b;

	logic [`VADD_DATA_WIDTH-1:0] sum_data;
	logic                        sum_valid, sum_last, sum_ready;

	assign start_ok = start && !busy; // Starts during a command are dropped

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			mode_q <= vadd_pkg::MODE_WORD;
		end else if (start_ok) begin
			busy   <= 1'b1;
			mode_q <= mode;
		end else if (bvalid && bready) begin
			busy <= 1'b0; // Low while done is high
		end
	end

	axi_word_mem mem_i (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr_a), .arlen(arlen_a), .arvalid(arvalid_a), .arready(arready_a),
		.rdata(rdata_a), .rvalid(rvalid_a), .rlast(rlast_a), .rready(rready_a),
		.araddr_2(araddr_b), .arlen_2(arlen_b), .arvalid_2(arvalid_b),
		.arready_2(arready_b), .rdata_2(rdata_b), .rvalid_2(rvalid_b),
		.rlast_2(), .rready_2(rready_b) // Channel 1 rlast marks the end
	);

	burst_reader rd_a_i (
		.clk(clk), .rst_n(rst_n), .start(start_ok), .base(src_a), .len(len),
		.araddr(araddr_a), .arlen(arlen_a), .arvalid(arvalid_a), .arready(arready_a)
	);

	burst_reader rd_b_i (
		.clk(clk), .rst_n(rst_n), .start(start_ok), .base(src_b), .len(len),
		.araddr(araddr_b), .arlen(arlen_b), .arvalid(arvalid_b), .arready(arready_b)
	);

	lane_adder add_i (
		.clk(clk), .rst_n(rst_n), .mode(mode_q),
		.a_data(rdata_a), .a_valid(rvalid_a), .a_last(rlast_a),
		.b_data(rdata_b), .b_valid(rvalid_b),
		.a_ready(rready_a), .b_ready(rready_b),
		.sum_data(sum_data), .sum_valid(sum_valid), .sum_last(sum_last),
		.sum_ready(sum_ready)
	);

	burst_writer wr_i (
		.clk(clk), .rst_n(rst_n), .start(start_ok), .base(dst), .len(len),
		.sum_data(sum_data), .sum_valid(sum_valid), .sum_last(sum_last),
		.sum_ready(sum_ready),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.done(done), .resp(resp), .checksum(checksum)
	);

endmodule

// ==== hdl/burst_writer.sv ====
// Write side of the engine, streams sums as one burst and keeps a running checksum
`timescale 1ns/1ps
`include "vadd_settings.svh"

module burst_writer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [`VADD_ADDR_WIDTH-1:0] base,
	input  axi_pkg::len_t               len,
	input  logic [`VADD_DATA_WIDTH-1:0] sum_data,
	input  logic                        sum_valid,
	input  logic                        sum_last,
	output logic                        sum_ready,
	output logic [`VADD_ADDR_WIDTH-1:0] awaddr,
	output axi_pkg::len_t               awlen,
	output logic                        awvalid,
	input  logic                        awready,
	output logic [`VADD_DATA_WIDTH-1:0] wdata,
	output logic                        wvalid,
	output logic                        wlast,
	input  logic                        wready,
	input  axi_pkg::resp_t              bresp,
	input  logic                        bvalid,
	output logic                        bready,
	output logic                        done,
	output axi_pkg::resp_t              resp,
	output logic [`VADD_DATA_WIDTH-1:0] checksum
);

	logic data_phase; // From start to the wlast beat
	logic resp_phase; // Waiting on bvalid

	// Sum register feeds w directly
	assign wvalid    = data_phase && sum_valid;
	assign wdata     = sum_data;
	assign wlast     = sum_last;
	assign sum_ready = wvalid && wready; // Back-pressure into the adder
	assign bready    = resp_phase;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awvalid    <= 1'b0;
			awaddr     <= '0;
			awlen      <= '0;
			data_phase <= 1'b0;
			resp_phase <= 1'b0;
			done       <= 1'b0;
			resp       <= axi_pkg::RESP_OKAY;
			checksum   <= '0;
		end else begin
			done <= 1'b0; // Single-cycle pulse
			if (start) begin
				awaddr     <= base;
				awlen      <= len;
				awvalid    <= 1'b1;
				data_phase <= 1'b1;
				checksum   <= '0; // Fresh sum per command
			end else if (awvalid && awready) begin
				awvalid <= 1'b0;
			end

			if (sum_ready) begin
				checksum <= checksum + wdata; // Wraps at 32 bits
				if (wlast) begin
					data_phase <= 1'b0;
					resp_phase <= 1'b1;
				end
			end

			// Response taken, done follows one cycle later
			if (bvalid && bready) begin
				resp_phase <= 1'b0;
				resp       <= bresp;
				done       <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/lane_adder.sv ====
// Joins the two operand streams and registers one word or lane sum per beat
`timescale 1ns/1ps
`include "vadd_settings.svh"

module lane_adder (
	input  logic                        clk,
	input  logic                        rst_n,
	input  vadd_pkg::mode_t             mode,
	input  logic [`VADD_DATA_WIDTH-1:0] a_data,
	input  logic                        a_valid,
	input  logic                        a_last,
	input  logic [`VADD_DATA_WIDTH-1:0] b_data,
	input  logic                        b_valid,
	output logic                        a_ready,
	output logic                        b_ready,
	output logic [`VADD_DATA_WIDTH-1:0] sum_data,
	output logic                        sum_valid,
	output logic                        sum_last,
	input  logic                        sum_ready
);

	vadd_pkg::word_u a_u;
	vadd_pkg::word_u b_u;
	vadd_pkg::word_u s_u;
	logic            take; // Joint beat consumed this cycle

	assign a_u = a_data;
	assign b_u = b_data;

	// Both beats present and the output slot free or draining
	assign take    = a_valid && b_valid && (!sum_valid || sum_ready);
	assign a_ready = take;
	assign b_ready = take; // Same enable, streams stay aligned

	always_comb begin
		s_u.word = a_u.word + b_u.word; // Carries ripple across bytes
		if (mode == vadd_pkg::MODE_LANE) begin
			for (int i = 0; i < `VADD_DATA_WIDTH / 8; i++)
				s_u.lane[i] = a_u.lane[i] + b_u.lane[i]; // Carry dropped per lane
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_valid <= 1'b0;
			sum_last  <= 1'b0;
			sum_data  <= '0;
		end else if (take) begin
			sum_valid <= 1'b1;
			sum_data  <= s_u.word;
			sum_last  <= a_last; // Both bursts have the same length
		end else if (sum_ready) begin
			sum_valid <= 1'b0;
		end
	end

endmodule

// ==== hdl/burst_reader.sv ====
// Read request side of one operand stream, one burst per start pulse
`timescale 1ns/1ps
`include "vadd_settings.svh"

module burst_reader (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,   // Accepted host command
	input  logic [`VADD_ADDR_WIDTH-1:0] base,    // First source word
	input  axi_pkg::len_t               len,     // Beats minus one
	output logic [`VADD_ADDR_WIDTH-1:0] araddr,
	output axi_pkg::len_t               arlen,
	output logic                        arvalid,
	input  logic                        arready
);

	// Data beats go straight from the memory to the adder
	// This block only raises the request and holds it

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arvalid <= 1'b0;
			araddr  <= '0;
			arlen   <= '0;
		end else if (start) begin
			araddr  <= base; // Latched, host may change it after start
			arlen   <= len;
			arvalid <= 1'b1; // One cycle after start
		end else if (arvalid && arready) begin
			arvalid <= 1'b0; // Request taken
		end
	end

endmodule

// ==== hdl/axi_word_mem.sv ====
// Word-addressed burst memory with one write and two read channels, pattern-loaded at reset
`timescale 1ns/1ps
`include "vadd_settings.svh"

module axi_word_mem (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`VADD_ADDR_WIDTH-1:0] awaddr,
	input  axi_pkg::len_t               awlen,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`VADD_DATA_WIDTH-1:0] wdata,
	input  logic                        wvalid,
	input  logic                        wlast,
	output logic                        wready,
	output axi_pkg::resp_t              bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`VADD_ADDR_WIDTH-1:0] araddr,
	input  axi_pkg::len_t               arlen,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`VADD_DATA_WIDTH-1:0] rdata,
	output logic                        rvalid,
	output logic                        rlast,
	input  logic                        rready,
	input  logic [`VADD_ADDR_WIDTH-1:0] araddr_2,
	input  axi_pkg::len_t               arlen_2,
	input  logic                        arvalid_2,
	output logic                        arready_2,
	output logic [`VADD_DATA_WIDTH-1:0] rdata_2,
	output logic                        rvalid_2,
	output logic                        rlast_2,
	input  logic                        rready_2
);

	localparam logic [`VADD_DATA_WIDTH-1:0] FILL_STEP = 32'h0001_0003; // Reset pattern step

	logic [`VADD_DATA_WIDTH-1:0] mem [`VADD_MEM_WORDS];

	logic [`VADD_ADDR_WIDTH-1:0] wr_addr; // Advances per beat
	axi_pkg::len_t               wr_len;
	axi_pkg::len_t               wr_cnt;
	logic                        aw_take;

	// Read channels as arrays, index 0 is channel 1
	logic [`VADD_ADDR_WIDTH-1:0] ch_araddr [2];
	axi_pkg::len_t               ch_arlen [2];
	logic                        ch_arvalid [2];
	logic                        ch_rready [2];
	logic                        ch_arready [2];
	logic [`VADD_DATA_WIDTH-1:0] ch_rdata [2];
	logic                        ch_rvalid [2];
	logic                        ch_rlast [2];

	// Accept a new write burst only when idle
	assign aw_take = awvalid && !awready && !wready && !bvalid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= axi_pkg::RESP_OKAY;
			wr_addr <= '0;
			wr_len  <= '0;
			wr_cnt  <= '0;
			for (int i = 0; i < `VADD_MEM_WORDS; i++)
				mem[i] <= i * FILL_STEP; // Wraps at 32 bits
		end else begin
			awready <= aw_take; // One-cycle pulse
			if (aw_take) begin
				wready  <= 1'b1; // Open with awready
				wr_addr <= awaddr;
				wr_len  <= awlen;
				wr_cnt  <= '0;
			end
			if (wvalid && wready) begin
				mem[wr_addr] <= wdata;
				wr_addr      <= wr_addr + 1'b1;
				wr_cnt       <= wr_cnt + 1'b1;
				// Close on wlast, or once awlen beats are in
				if (wlast || wr_cnt == wr_len) begin
					wready <= 1'b0;
					bvalid <= 1'b1;
					bresp  <= axi_pkg::RESP_OKAY;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0; // Held until taken
		end
	end

	assign ch_araddr[0]  = araddr;
	assign ch_araddr[1]  = araddr_2;
	assign ch_arlen[0]   = arlen;
	assign ch_arlen[1]   = arlen_2;
	assign ch_arvalid[0] = arvalid;
	assign ch_arvalid[1] = arvalid_2;
	assign ch_rready[0]  = rready;
	assign ch_rready[1]  = rready_2;

	for (genvar g = 0; g < 2; g++) begin : g_rd
		logic [`VADD_ADDR_WIDTH-1:0] rd_addr; // Next word to fetch
		axi_pkg::len_t               rd_len;
		axi_pkg::len_t               rd_cnt;  // Beat now on rdata

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				ch_arready[g] <= 1'b0;
				ch_rvalid[g]  <= 1'b0;
				ch_rlast[g]   <= 1'b0;
				ch_rdata[g]   <= '0;
				rd_addr       <= '0;
				rd_len        <= '0;
				rd_cnt        <= '0;
			end else begin
				ch_arready[g] <= ch_arvalid[g] && !ch_arready[g] && !ch_rvalid[g];
				if (ch_arvalid[g] && ch_arready[g]) begin
					// First word comes straight from araddr
					ch_rvalid[g] <= 1'b1;
					ch_rdata[g]  <= mem[ch_araddr[g]];
					ch_rlast[g]  <= (ch_arlen[g] == '0);
					rd_addr      <= ch_araddr[g] + 1'b1;
					rd_len       <= ch_arlen[g];
					rd_cnt       <= '0;
				end else if (ch_rvalid[g] && ch_rready[g]) begin
					if (ch_rlast[g]) begin
						ch_rvalid[g] <= 1'b0; // Burst over
						ch_rlast[g]  <= 1'b0;
					end else begin
						ch_rdata[g] <= mem[rd_addr];
						rd_addr     <= rd_addr + 1'b1;
						rd_cnt      <= rd_cnt + 1'b1;
						ch_rlast[g] <= (rd_cnt + 1'b1 == rd_len);
					end
				end
			end
		end
	end

	assign arready   = ch_arready[0];
	assign rdata     = ch_rdata[0];
	assign rvalid    = ch_rvalid[0];
	assign rlast     = ch_rlast[0];
	assign arready_2 = ch_arready[1];
	assign rdata_2   = ch_rdata[1];
	assign rvalid_2  = ch_rvalid[1];
	assign rlast_2   = ch_rlast[1];

endmodule

// ==== hdl/vadd_pkg.sv ====
// Arithmetic types of the vector-add engine, used by the lane adder and the top level
`include "vadd_settings.svh"

package vadd_pkg;

	// Add mode, latched per command
	typedef enum logic {
		MODE_WORD = 1'b0, // One 32-bit sum per word
		MODE_LANE = 1'b1  // Four wrapping 8-bit sums
	} mode_t;

	// One data word seen two ways
	typedef union packed {
		logic [`VADD_DATA_WIDTH-1:0]         word; // Whole scalar
		logic [`VADD_DATA_WIDTH/8-1:0][7:0] lane; // Lane 0 in low byte
	} word_u;

endpackage

// ==== hdl/axi_pkg.sv ====
// Memory bus types shared by the word memory, the burst reader and the burst writer
package axi_pkg;

	// Write response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10 // Reserved, never sent by this memory
	} resp_t;

	// Burst length, beats minus one
	typedef logic [7:0] len_t;

endpackage

// ==== hdl/vadd_settings.svh ====
// Sizing macros for the vector-add engine, included by every RTL file that needs widths
`ifndef VADD_SETTINGS_SVH
`define VADD_SETTINGS_SVH

// Word address, one step per word
`define VADD_ADDR_WIDTH 10

// Data word, four 8-bit lanes in lane mode
`define VADD_DATA_WIDTH 32

// Memory depth in words
`define VADD_MEM_WORDS 1024

`endif
